/* all.f */
+incdir+hw
hw/tpl_dac_pkg.sv
hw/tpl_dac_framer.sv
hw/tpl_dac_lmfc_counter.sv
hw/tpl_dac_ctrl.sv
hw/tpl_dac_sample_src.sv
hw/tpl_dac_top.sv
tb/tpl_dac_checker.sv
tb/tpl_dac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tpl_dac_tb -f all.f -o tpl_dac_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tpl_dac_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

/* tb/tpl_dac_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_tb import tpl_dac_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int BEATS        = `TPL_BEATS_PER_MULTIFRAME;
  localparam int IDLE_LEN     = 40;
  localparam int DAC_BEATS    = 64;
  // The ramp advances by 2 per beat, so 8192 beats take it through a wrap
  localparam int RAMP_BEATS   = 8200;
  localparam int ZERO_BEATS   = 24;
  localparam int STOP_BEATS   = 16;
  // Handshakes, start waits and gaps of one test
  localparam int OVERHEAD     = 64;
  localparam int TEST_CYCLES  = IDLE_LEN + DAC_BEATS + RAMP_BEATS + ZERO_BEATS +
                                3 * STOP_BEATS + 6 * OVERHEAD;
  localparam int MAX_CYCLES   = 2 * TEST_CYCLES + RESET_CYCLES;

  logic                            link_clk;
  logic                            rst_n;
  logic                            cfg_req;
  logic                            cfg_enable;
  tpl_src_e                        cfg_src;
  logic                            cfg_ack;
  logic                            link_sync;
  logic                            sysref;
  logic [`TPL_DAC_DATA_WIDTH-1:0]  dac_data;
  logic                            dac_rd;
  logic [`TPL_LINK_DATA_WIDTH-1:0] link_data;
  logic                            link_valid;
  logic [3:0]                      test_num;
  logic [31:0]                     lfsr;
  int                              tb_errors;
  int                              chk_errors;
  int                              chk_checks;
  int                              cycles;
  int                              total_errors;

  // ****************************************
  // DUT and checker
  // ****************************************

  tpl_dac_top i_dut (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .cfg_req    (cfg_req),
    .cfg_enable (cfg_enable),
    .cfg_src    (cfg_src),
    .cfg_ack    (cfg_ack),
    .link_sync  (link_sync),
    .sysref     (sysref),
    .dac_data   (dac_data),
    .dac_rd     (dac_rd),
    .link_data  (link_data),
    .link_valid (link_valid)
  );

  tpl_dac_checker i_chk (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .cfg_req    (cfg_req),
    .cfg_enable (cfg_enable),
    .cfg_src    (cfg_src),
    .cfg_ack    (cfg_ack),
    .link_sync  (link_sync),
    .sysref     (sysref),
    .dac_data   (dac_data),
    .dac_rd     (dac_rd),
    .link_data  (link_data),
    .link_valid (link_valid),
    .test_num   (test_num),
    .errors     (chk_errors),
    .checks     (chk_checks)
  );

  initial begin
    link_clk = 1'b0;
    forever #20 link_clk = ~link_clk;
  end

  // ****************************************
  // Stimulus helpers
  // ****************************************

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic next_dac_data(output logic [`TPL_DAC_DATA_WIDTH-1:0] word);
    for (int i = 0; i < `TPL_DAC_DATA_WIDTH; i++) begin
      lfsr    = lfsr_step(lfsr);
      word[i] = lfsr[0];
    end
  endtask

  task automatic start_test(input logic [3:0] n);
    @(posedge link_clk);
    test_num <= n;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge link_clk);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    @(posedge link_clk);
    while (cfg_ack !== level && n < 8) begin
      @(posedge link_clk);
      n++;
    end
    if (cfg_ack !== level) begin
      $display("cfg_ack did not go to %0b within 8 cycles of cfg_req", level);
      tb_errors++;
    end
  endtask

  // Full four-phase handshake, returns only once cfg_ack is low again
  task automatic configure(input logic enable, input tpl_src_e src);
    @(posedge link_clk);
    cfg_enable <= enable;
    cfg_src    <= src;
    cfg_req    <= 1'b1;
    wait_ack(1'b1);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic pulse_sysref();
    @(posedge link_clk);
    sysref <= 1'b1;
    @(posedge link_clk);
    sysref <= 1'b0;
  endtask

  task automatic set_sync(input logic level);
    @(posedge link_clk);
    link_sync <= level;
  endtask

  // Start has to come within a few multiframes of sync and enable
  task automatic wait_for_run();
    int n;
    n = 0;
    @(posedge link_clk);
    while (!dac_rd && n < 3 * BEATS) begin
      @(posedge link_clk);
      n++;
    end
    if (!dac_rd) begin
      $display("dac_rd did not rise within %0d cycles of sync and enable", 3 * BEATS);
      tb_errors++;
    end
  endtask

  task automatic run_beats(input int n);
    logic [`TPL_DAC_DATA_WIDTH-1:0] word;
    repeat (n) begin
      next_dac_data(word);
      @(posedge link_clk);
      dac_data <= word;
    end
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    rst_n      <= 1'b0;
    cfg_req    <= 1'b0;
    cfg_enable <= 1'b0;
    cfg_src    <= SRC_DAC;
    link_sync  <= 1'b0;
    sysref     <= 1'b0;
    dac_data   <= '0;
    test_num   <= 4'd0;
    lfsr       = 32'h5eae_0fe0;
    tb_errors  = 0;
    repeat (RESET_CYCLES) @(posedge link_clk);
    rst_n <= 1'b1;

    // Sync and sysref present but the enable is clear
    start_test(4'd1);
    set_sync(1'b1);
    pulse_sysref();
    run_beats(IDLE_LEN);
    set_sync(1'b0);

    // Back-to-back configurations with the link out of sync
    start_test(4'd2);
    configure(1'b1, SRC_RAMP);
    configure(1'b0, SRC_ZERO);
    configure(1'b1, SRC_DAC);
    idle_cycles(4);

    start_test(4'd3);
    pulse_sysref();
    set_sync(1'b1);
    wait_for_run();
    run_beats(DAC_BEATS);
    set_sync(1'b0);
    idle_cycles(4);

    start_test(4'd4);
    configure(1'b1, SRC_RAMP);
    set_sync(1'b1);
    wait_for_run();
    run_beats(RAMP_BEATS);
    set_sync(1'b0);
    idle_cycles(4);

    start_test(4'd5);
    configure(1'b1, SRC_ZERO);
    set_sync(1'b1);
    wait_for_run();
    run_beats(ZERO_BEATS);
    set_sync(1'b0);
    idle_cycles(4);

    // Sync loss, then enable cleared, then a restart on a shifted multiframe
    start_test(4'd6);
    configure(1'b1, SRC_DAC);
    set_sync(1'b1);
    wait_for_run();
    run_beats(STOP_BEATS);
    set_sync(1'b0);
    idle_cycles(4);
    set_sync(1'b1);
    wait_for_run();
    run_beats(STOP_BEATS);
    configure(1'b0, SRC_DAC);
    idle_cycles(7);
    pulse_sysref();
    configure(1'b1, SRC_DAC);
    wait_for_run();
    run_beats(STOP_BEATS);
    set_sync(1'b0);
    idle_cycles(4);

    start_test(4'd7);
    repeat (2) @(posedge link_clk);
    @(negedge link_clk);
    total_errors = chk_errors + tb_errors;
    $display("summary: %0d checks, %0d errors", chk_checks, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit from the summed test lengths
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge link_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tpl_dac_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_checker import tpl_dac_pkg::*; (
  input  wire logic                            link_clk,
  input  wire logic                            rst_n,
  input  wire logic                            cfg_req,
  input  wire logic                            cfg_enable,
  input  wire tpl_src_e                        cfg_src,
  input  wire logic                            cfg_ack,
  input  wire logic                            link_sync,
  input  wire logic                            sysref,
  input  wire logic [`TPL_DAC_DATA_WIDTH-1:0]  dac_data,
  input  wire logic                            dac_rd,
  input  wire logic [`TPL_LINK_DATA_WIDTH-1:0] link_data,
  input  wire logic                            link_valid,
  // Number of the test that the stimulus is running, 0 before the first
  input  wire logic [3:0]                      test_num,
  output int                                   errors,
  output int                                   checks
);

  // Values seen on the previous edge
  logic        req_q;
  logic        ack_q;
  logic        rd_q;
  // Mirrored multiframe count of this cycle and of the cycle before
  logic [2:0]  cnt_q;
  logic [2:0]  cnt_last;
  // Configuration as the host completed it
  logic        en_model;
  tpl_src_e    src_model;
  // Expected controller state in the current cycle
  logic        wait_model;
  logic        run_model;
  logic [13:0] ramp_r;
  // Expected link_data for the beat read on the previous edge
  logic [`TPL_LINK_DATA_WIDTH-1:0] exp_data;
  logic [3:0]  test_q;
  int          errors_at_start;
  int          checks_at_start;

  // ****************************************
  // Reference model
  // ****************************************

  // Lane L carries channel L. Its octets are frame 0 high, frame 0 low,
  // frame 1 high, frame 1 low, where frame f holds the channel's sample f
  // widened by two zero tail bits
  function automatic logic [`TPL_LINK_DATA_WIDTH-1:0] map_beat(
    input logic [`TPL_DAC_DATA_WIDTH-1:0] samples
  );
    logic [`TPL_LINK_DATA_WIDTH-1:0] lanes;
    logic [15:0]                     wide;
    lanes = '0;
    for (int lane = 0; lane < 2; lane++) begin
      for (int frame = 0; frame < 2; frame++) begin
        // Channel 0 owns samples 0 and 1, channel 1 owns samples 2 and 3
        wide = {samples[(lane * 2 + frame) * 14 +: 14], 2'b00};
        lanes[lane * 32 + frame * 16 +: 8]     = wide[15:8];
        lanes[lane * 32 + frame * 16 + 8 +: 8] = wide[7:0];
      end
    end
    return lanes;
  endfunction

  // Each channel gets r then r + 1, both wrapping at 14 bits
  function automatic logic [`TPL_DAC_DATA_WIDTH-1:0] ramp_beat(input logic [13:0] r);
    logic [`TPL_DAC_DATA_WIDTH-1:0] word;
    word = '0;
    for (int ch = 0; ch < 2; ch++) begin
      word[(ch * 2) * 14 +: 14]     = r;
      word[(ch * 2 + 1) * 14 +: 14] = r + 14'd1;
    end
    return word;
  endfunction

  function automatic string test_name(input logic [3:0] n);
    case (n)
      4'd1:    return "idle after reset";
      4'd2:    return "configuration handshake";
      4'd3:    return "dac source";
      4'd4:    return "ramp source";
      4'd5:    return "zero source";
      4'd6:    return "stop and restart";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // ****************************************
  // Per-edge comparison
  // ****************************************

  always @(posedge link_clk) begin
    if (!rst_n) begin
      req_q           = 1'b0;
      ack_q           = 1'b0;
      rd_q            = 1'b0;
      cnt_q           = 3'd0;
      cnt_last        = 3'd0;
      en_model        = 1'b0;
      src_model       = SRC_DAC;
      wait_model      = 1'b0;
      run_model       = 1'b0;
      ramp_r          = 14'd0;
      exp_data        = '0;
      errors          = 0;
      checks          = 0;
      errors_at_start = 0;
      checks_at_start = 0;
      test_q          = test_num;
    end else begin
      // Acknowledge follows the request one cycle later, in both directions
      check_value("cfg_ack", 64'(req_q), 64'(cfg_ack));

      // Reads follow the modelled state machine
      check_value("dac_rd", 64'(run_model), 64'(dac_rd));

      // A start must follow a cycle in which the mirrored count was 7
      if (dac_rd && !rd_q) begin
        check_value("lmfc count before dac_rd rise", 64'(7), 64'(cnt_last));
      end

      // Output side trails the read by exactly one cycle
      check_value("link_valid", 64'(rd_q), 64'(link_valid));
      if (rd_q) begin
        check_value("link_data", exp_data, link_data);
      end else begin
        check_value("link_data", 64'(0), link_data);
      end

      // The host holds its data while the request is up, so the rising
      // acknowledge marks a completed configuration. The new source is
      // already in use for the beat read on this edge
      if (cfg_ack && !ack_q) begin
        en_model  = cfg_enable;
        src_model = cfg_src;
      end

      // Predict the beat that this edge reads
      if (dac_rd) begin
        case (src_model)
          SRC_DAC: begin
            exp_data = map_beat(dac_data);
          end
          SRC_RAMP: begin
            exp_data = map_beat(ramp_beat(ramp_r));
            ramp_r   = ramp_r + 14'd2;
          end
          default: begin
            exp_data = '0;
          end
        endcase
      end else begin
        ramp_r   = 14'd0;
        exp_data = '0;
      end

      // Sync and enable start the wait, a count-7 cycle then starts the run,
      // and losing either one goes back to idle
      run_model  = en_model && link_sync &&
                   (run_model || (wait_model && cnt_q == 3'd7));
      wait_model = en_model && link_sync && !run_model;

      cnt_last = cnt_q;
      if (sysref || cnt_q == 3'd7) begin
        cnt_q = 3'd0;
      end else begin
        cnt_q = cnt_q + 3'd1;
      end

      req_q  = cfg_req;
      ack_q  = cfg_ack;
      rd_q   = dac_rd;

      // One summary line as each test hands over to the next
      if (test_num != test_q) begin
        if (test_q != 4'd0) begin
          $display("test %0d %s: %0d checks, %0d errors", test_q, test_name(test_q),
                   checks - checks_at_start, errors - errors_at_start);
        end
        test_q          = test_num;
        errors_at_start = errors;
        checks_at_start = checks;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tpl_dac_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_top import tpl_dac_pkg::*; (
  input  wire logic                            link_clk,
  input  wire logic                            rst_n,
  // Host configuration
  input  wire logic                            cfg_req,
  input  wire logic                            cfg_enable,
  input  tpl_src_e                             cfg_src,
  output logic                                 cfg_ack,
  // Link layer and alignment
  input  wire logic                            link_sync,
  input  wire logic                            sysref,
  // Converter samples in
  input  wire logic [`TPL_DAC_DATA_WIDTH-1:0]  dac_data,
  output logic                                 dac_rd,
  // Lane octets out
  output logic      [`TPL_LINK_DATA_WIDTH-1:0] link_data,
  output logic                                 link_valid
);

  logic                           lmfc_edge;
  logic                           run;
  tpl_src_e                       src;
  logic [`TPL_DAC_DATA_WIDTH-1:0] sample_data;

  // ****************************************
  // Control path
  // ****************************************

  tpl_dac_lmfc_counter i_lmfc (
    .link_clk  (link_clk),
    .rst_n     (rst_n),
    .sysref    (sysref),
    .lmfc_edge (lmfc_edge)
  );

  tpl_dac_ctrl i_ctrl (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .cfg_req    (cfg_req),
    .cfg_enable (cfg_enable),
    .cfg_src    (cfg_src),
    .cfg_ack    (cfg_ack),
    .link_sync  (link_sync),
    .lmfc_edge  (lmfc_edge),
    .run        (run),
    .src        (src),
    .dac_rd     (dac_rd)
  );

  // ****************************************
  // Datapath
  // ****************************************

  tpl_dac_sample_src i_src (
    .link_clk    (link_clk),
    .rst_n       (rst_n),
    .run         (run),
    .src         (src),
    .dac_data    (dac_data),
    .sample_data (sample_data),
    .link_valid  (link_valid)
  );

  // Framer adds no latency, so link_data lines up with link_valid
  tpl_dac_framer #(
    .NUM_LANES            (`TPL_NUM_LANES),
    .NUM_CHANNELS         (`TPL_NUM_CHANNELS),
    .BITS_PER_SAMPLE      (`TPL_BITS_PER_SAMPLE),
    .CONVERTER_RESOLUTION (`TPL_CONVERTER_RESOLUTION),
    .SAMPLES_PER_FRAME    (`TPL_SAMPLES_PER_FRAME),
    .OCTETS_PER_BEAT      (`TPL_OCTETS_PER_BEAT)
  ) i_framer (
    .dac_data  (sample_data),
    .link_data (link_data)
  );

endmodule

`default_nettype wire

/* hw/tpl_dac_sample_src.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_sample_src import tpl_dac_pkg::*; (
  input  wire logic                           link_clk,
  input  wire logic                           rst_n,
  input  wire logic                           run,
  input  tpl_src_e                            src,
  input  wire logic [`TPL_DAC_DATA_WIDTH-1:0] dac_data,
  // Registered samples for the framer
  output logic      [`TPL_DAC_DATA_WIDTH-1:0] sample_data,
  output logic                                link_valid
);

  localparam int RES = `TPL_CONVERTER_RESOLUTION;
  localparam int SAMPLES_PER_BEAT = `TPL_DAC_DATA_WIDTH / RES;
  // Each channel gets this many consecutive ramp values per beat
  localparam int SAMPLES_PER_CHANNEL = SAMPLES_PER_BEAT / `TPL_NUM_CHANNELS;

  logic [RES-1:0]                 ramp_q;
  logic [`TPL_DAC_DATA_WIDTH-1:0] ramp_word;
  logic [`TPL_DAC_DATA_WIDTH-1:0] sel_word;

  // ****************************************
  // Ramp generator
  // ****************************************

  // Ramp restarts from zero every time the datapath starts again
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      ramp_q <= '0;
    end else if (!run) begin
      ramp_q <= '0;
    end else begin
      ramp_q <= ramp_q + RES'(SAMPLES_PER_CHANNEL);
    end
  end

  // Sample k of every channel carries r + k, wrapping at the resolution
  always_comb begin
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      ramp_word[i * RES +: RES] = ramp_q + RES'(i % SAMPLES_PER_CHANNEL);
    end
  end

  always_comb begin
    case (src)
      SRC_DAC:  sel_word = dac_data;
      SRC_RAMP: sel_word = ramp_word;
      default:  sel_word = '0;
    endcase
  end

  // Output register, zeros whenever the datapath is stopped
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_data <= '0;
      link_valid  <= 1'b0;
    end else begin
      sample_data <= run ? sel_word : '0;
      link_valid  <= run;
    end
  end

  // The host must not configure the undefined source code before starting
  a_src_legal : assert property (@(posedge link_clk) disable iff (!rst_n)
    run |-> src inside {SRC_DAC, SRC_RAMP, SRC_ZERO});

endmodule

`default_nettype wire

/* hw/tpl_dac_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_dac_ctrl import tpl_dac_pkg::*; (
  input  wire logic     link_clk,
  input  wire logic     rst_n,
  // Host configuration port, four-phase req/ack
  input  wire logic     cfg_req,
  input  wire logic     cfg_enable,
  input  tpl_src_e      cfg_src,
  output logic          cfg_ack,
  // Link layer status and local multiframe boundary
  input  wire logic     link_sync,
  input  wire logic     lmfc_edge,
  // Datapath control
  output logic          run,
  output tpl_src_e      src,
  output logic          dac_rd
);

  tpl_state_e state_q;
  tpl_state_e state_d;
  logic       enable_q;
  // Data may only flow with the host enable set and the link in sync
  logic       go;

  // ****************************************
  // Configuration handshake
  // ****************************************

  // Acknowledge follows request by one cycle in both directions. The
  // configuration is taken on the edge where the request is first seen
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack  <= 1'b0;
      enable_q <= 1'b0;
      src      <= SRC_DAC;
    end else begin
      cfg_ack <= cfg_req;
      if (cfg_req && !cfg_ack) begin
        enable_q <= cfg_enable;
        src      <= cfg_src;
      end
    end
  end

  // ****************************************
  // Link state machine
  // ****************************************

  assign go = enable_q && link_sync;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (go) begin
          state_d = WAIT_LMFC;
        end
      end
      WAIT_LMFC: begin
        // Start lines up with the next local multiframe
        if (!go) begin
          state_d = IDLE;
        end else if (lmfc_edge) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (!go) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign run    = (state_q == RUN);
  // Samples are taken from the input on every running beat
  assign dac_rd = run;

  // A new request may only come once the acknowledge has dropped
  a_ack_held : assert property (@(posedge link_clk) disable iff (!rst_n)
    $fell(cfg_ack) |-> !cfg_req);

  // Data only starts right after a multiframe boundary from the counter
  a_run_on_lmfc : assert property (@(posedge link_clk) disable iff (!rst_n)
    $rose(run) |-> $past(lmfc_edge));

endmodule

`default_nettype wire

/* hw/tpl_dac_lmfc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_lmfc_counter (
  input  wire logic link_clk,
  input  wire logic rst_n,
  // One-cycle alignment pulse from the clock distribution
  input  wire logic sysref,
  // High in the last beat of each local multiframe
  output logic      lmfc_edge
);

  localparam int BEATS   = `TPL_BEATS_PER_MULTIFRAME;
  localparam int COUNT_W = $clog2(BEATS);

  logic [COUNT_W-1:0] beat_cnt;

  // ****************************************
  // Multiframe beat counter
  // ****************************************

  // sysref forces the count to zero on the edge it is seen, so the
  // multiframe restarts in phase with it
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (sysref) begin
      beat_cnt <= '0;
    end else if (beat_cnt == COUNT_W'(BEATS - 1)) begin
      beat_cnt <= '0;
    end else begin
      beat_cnt <= beat_cnt + COUNT_W'(1);
    end
  end

  assign lmfc_edge = (beat_cnt == COUNT_W'(BEATS - 1));

  // Matters when the multiframe length is not a power of two
  a_cnt_range : assert property (@(posedge link_clk) disable iff (!rst_n)
    {1'b0, beat_cnt} < (COUNT_W + 1)'(BEATS));

endmodule

`default_nettype wire

/* hw/tpl_dac_framer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_settings.svh"

module tpl_dac_framer #(
  parameter int NUM_LANES            = `TPL_NUM_LANES,
  parameter int NUM_CHANNELS         = `TPL_NUM_CHANNELS,
  parameter int BITS_PER_SAMPLE      = `TPL_BITS_PER_SAMPLE,
  parameter int CONVERTER_RESOLUTION = `TPL_CONVERTER_RESOLUTION,
  parameter int SAMPLES_PER_FRAME    = `TPL_SAMPLES_PER_FRAME,
  parameter int OCTETS_PER_BEAT      = `TPL_OCTETS_PER_BEAT,
  parameter int LINK_DATA_WIDTH      = NUM_LANES * OCTETS_PER_BEAT * 8,
  parameter int DAC_DATA_WIDTH       =
    LINK_DATA_WIDTH * CONVERTER_RESOLUTION / BITS_PER_SAMPLE
) (
  // Converter samples, grouped per channel, earliest sample in the LSBs
  input  wire logic [DAC_DATA_WIDTH-1:0]  dac_data,
  // Lane octets, lane 0 in the LSBs, earliest octet lowest in each lane
  output logic      [LINK_DATA_WIDTH-1:0] link_data
);

  // The JESD204 frame format orders samples and octets MSB first while both
  // buses of this block are LSB first. The mapping therefore reverses the
  // sample order, groups and distributes in MSB-first space, and reverses
  // the octet order again at the end

  localparam int TAIL_BITS = BITS_PER_SAMPLE - CONVERTER_RESOLUTION;
  localparam int SAMPLES_PER_BEAT = DAC_DATA_WIDTH / CONVERTER_RESOLUTION;
  localparam int BITS_PER_CHANNEL_PER_FRAME = BITS_PER_SAMPLE * SAMPLES_PER_FRAME;
  localparam int BITS_PER_LANE_PER_FRAME =
    BITS_PER_CHANNEL_PER_FRAME * NUM_CHANNELS / NUM_LANES;
  // Octets per frame (F) follow from the other settings
  localparam int FRAMES_PER_BEAT = OCTETS_PER_BEAT * 8 / BITS_PER_LANE_PER_FRAME;

  logic [LINK_DATA_WIDTH-1:0] samples_msb;
  logic [LINK_DATA_WIDTH-1:0] frames_msb;
  logic [LINK_DATA_WIDTH-1:0] lanes_msb;

  // ****************************************
  // Tail bits and MSB-first sample order
  // ****************************************

  // Sample i lands at the top of the word minus i sample slots, the
  // converter bits on top and the zero tail bits right below them
  for (genvar i = 0; i < SAMPLES_PER_BEAT; i++) begin : g_sample
    localparam int DST_MSB = LINK_DATA_WIDTH - 1 - i * BITS_PER_SAMPLE;

    assign samples_msb[DST_MSB -: CONVERTER_RESOLUTION] =
      dac_data[i * CONVERTER_RESOLUTION +: CONVERTER_RESOLUTION];
    if (TAIL_BITS > 0) begin : g_tail
      assign samples_msb[DST_MSB - CONVERTER_RESOLUTION -: TAIL_BITS] = '0;
    end
  end

  // ****************************************
  // Channels into frames
  // ****************************************

  // In MSB-first space the source is ordered channel major, the frames
  // must be frame major with one slot per channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    for (genvar f = 0; f < FRAMES_PER_BEAT; f++) begin : g_frame
      localparam int W = BITS_PER_CHANNEL_PER_FRAME;

      assign frames_msb[(c + f * NUM_CHANNELS) * W +: W] =
        samples_msb[(f + c * FRAMES_PER_BEAT) * W +: W];
    end
  end

  // ****************************************
  // Frames onto lanes
  // ****************************************

  // Each frame is cut into one slice per lane, and every lane collects
  // its slices of all frames in the beat
  for (genvar f = 0; f < FRAMES_PER_BEAT; f++) begin : g_lane_frame
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      localparam int W = BITS_PER_LANE_PER_FRAME;

      assign lanes_msb[(f + l * FRAMES_PER_BEAT) * W +: W] =
        frames_msb[(l + f * NUM_LANES) * W +: W];
    end
  end

  // Back to LSB-first octet order, the bits inside an octet keep their place
  for (genvar o = 0; o < LINK_DATA_WIDTH / 8; o++) begin : g_octet
    assign link_data[o * 8 +: 8] = lanes_msb[LINK_DATA_WIDTH - 1 - o * 8 -: 8];
  end

endmodule

`default_nettype wire

/* hw/tpl_dac_pkg.sv */
`default_nettype none

package tpl_dac_pkg;

  // ****************************************
  // Controller state
  // ****************************************

  // IDLE holds the output quiet, WAIT_LMFC has sync and waits for the
  // multiframe boundary, RUN moves one beat per cycle
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    WAIT_LMFC = 2'd1,
    RUN       = 2'd2
  } tpl_state_e;

  // ****************************************
  // Sample source select
  // ****************************************

  // Code 2'd3 is not defined and must never reach the datapath while running
  typedef enum logic [1:0] {
    SRC_DAC  = 2'd0,
    SRC_RAMP = 2'd1,
    SRC_ZERO = 2'd2
  } tpl_src_e;

endpackage

`default_nettype wire

/* hw/tpl_dac_settings.svh */
`ifndef TPL_DAC_SETTINGS_SVH
`define TPL_DAC_SETTINGS_SVH

// ****************************************
// Link framing configuration
// ****************************************

// Number of JESD204 lanes (L)
`define TPL_NUM_LANES 2
// Number of converters (M)
`define TPL_NUM_CHANNELS 2
// Bits per sample on the link, including tail bits (N')
`define TPL_BITS_PER_SAMPLE 16
// Resolution of one converter sample (N)
`define TPL_CONVERTER_RESOLUTION 14
// Samples per converter per frame (S)
`define TPL_SAMPLES_PER_FRAME 1
// Octets each lane carries per link_clk beat
`define TPL_OCTETS_PER_BEAT 4

// Width of the lane octet bus, all lanes side by side
`define TPL_LINK_DATA_WIDTH (`TPL_NUM_LANES * `TPL_OCTETS_PER_BEAT * 8)
// Width of the converter sample bus, same beat without the tail bits
`define TPL_DAC_DATA_WIDTH \
  (`TPL_LINK_DATA_WIDTH * `TPL_CONVERTER_RESOLUTION / `TPL_BITS_PER_SAMPLE)

// Beats in one local multiframe
`define TPL_BEATS_PER_MULTIFRAME 8

`endif
